/* hdl/fibPkg.sv */
package fibPkg;

	////////////////////////////////////////
	// Geometry
	////////////////////////////////////////

	// Register file depth and select width
	localparam int REG_COUNT  = 16;
	localparam int REG_ADDR_W = 4;

	// Immediate field of a microcode step
	localparam int IMM_W = 8;

	////////////////////////////////////////
	// Types
	////////////////////////////////////////

	// ALU opcodes as carried in the microcode word
	typedef enum logic [7:0] {
		opOr     = 8'h02,
		opAdd    = 8'h05,
		opAddImm = 8'h50
	} aluOp_t;

	// One state per microcode step, step16 is the parking state
	typedef enum logic [4:0] {
		step0,  step1,  step2,  step3,
		step4,  step5,  step6,  step7,
		step8,  step9,  step10, step11,
		step12, step13, step14, step15,
		step16
	} seqState_t;

endpackage

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu import fibPkg::*; #(
	parameter int DATA_W = 16
) (
	input  aluOp_t            op,
	input  logic              selectImm,
	input  logic [IMM_W-1:0]  imm,
	input  logic [DATA_W-1:0] dataA,
	input  logic [DATA_W-1:0] dataB,
	output logic [DATA_W-1:0] result,
	output logic              zero
);

	logic [DATA_W-1:0] operandB;

	// Immediate is zero-extended to the data width
	assign operandB = selectImm ? DATA_W'(imm) : dataB;

	////////////////////////////////////////
	// Operation select
	////////////////////////////////////////

	always_comb begin
		case (op)
			// Both add flavours wrap at DATA_W bits
			opAdd, opAddImm: begin
				result = dataA + operandB;
			end
			opOr: begin
				result = dataA | operandB;
			end
			default: begin
				// Unknown opcode passes A through
				result = dataA;
			end
		endcase
	end

	assign zero = (result == '0);

endmodule

/* hdl/regFile.sv */
`timescale 1ns/1ps

module regFile import fibPkg::*; #(
	parameter int DATA_W = 16
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [REG_ADDR_W:0]   loadReg,
	input  logic [DATA_W-1:0]     writeData,
	input  logic [REG_ADDR_W-1:0] readRegA,
	input  logic [REG_ADDR_W-1:0] readRegB,
	input  logic [REG_ADDR_W-1:0] probeAddr,
	output logic [DATA_W-1:0]     dataA,
	output logic [DATA_W-1:0]     dataB,
	output logic [DATA_W-1:0]     probeData,
	output logic                  writeStrobe
);

	logic [DATA_W-1:0] regs [REG_COUNT];

	// Top bit of loadReg set means no write
	logic writeEnable;

	assign writeEnable = ~loadReg[REG_ADDR_W] & ~rst;
	assign writeStrobe = writeEnable;

	////////////////////////////////////////
	// Write port
	////////////////////////////////////////

	// Reset clears every register, writes ignored meanwhile
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable) begin
			regs[loadReg[REG_ADDR_W-1:0]] <= writeData;
		end
	end

	////////////////////////////////////////
	// Read ports
	////////////////////////////////////////

	// All three are combinational
	assign dataA     = regs[readRegA];
	assign dataB     = regs[readRegB];
	assign probeData = regs[probeAddr];

endmodule

/* hdl/fibSequencer.sv */
`timescale 1ns/1ps

module fibSequencer import fibPkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	output logic [REG_ADDR_W:0]   loadReg,
	output logic [REG_ADDR_W-1:0] readRegA,
	output logic [REG_ADDR_W-1:0] readRegB,
	output logic                  selectImm,
	output logic [IMM_W-1:0]      imm,
	output aluOp_t                op,
	output logic                  done
);

	seqState_t state;
	seqState_t nextState;

	// Raw step number, used to derive register selects
	logic [4:0] stepIdx;

	assign stepIdx = state;

	////////////////////////////////////////
	// State register
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= step0;
		end else begin
			state <= nextState;
		end
	end

	// One step per cycle, park in step16
	always_comb begin
		case (state)
			step0:   nextState = step1;
			step1:   nextState = step2;
			step2:   nextState = step3;
			step3:   nextState = step4;
			step4:   nextState = step5;
			step5:   nextState = step6;
			step6:   nextState = step7;
			step7:   nextState = step8;
			step8:   nextState = step9;
			step9:   nextState = step10;
			step10:  nextState = step11;
			step11:  nextState = step12;
			step12:  nextState = step13;
			step13:  nextState = step14;
			step14:  nextState = step15;
			step15:  nextState = step16;
			step16:  nextState = step16;
			// Illegal encodings restart the program
			default: nextState = step0;
		endcase
	end

	////////////////////////////////////////
	// Control field decode
	////////////////////////////////////////

	always_comb begin
		// Register-register add, no write
		selectImm = 1'b0;
		imm       = '0;
		op        = opAdd;
		loadReg   = {1'b1, {REG_ADDR_W{1'b0}}};
		readRegA  = '0;
		readRegB  = '0;
		done      = 1'b0;

		case (state)
			step0, step1: begin
				// r0 and r1 = r2 + 1, r2 is still zero here
				selectImm = 1'b1;
				imm       = IMM_W'(1);
				op        = opAddImm;
				loadReg   = {1'b0, stepIdx[REG_ADDR_W-1:0]};
				readRegA  = REG_ADDR_W'(2);
				readRegB  = REG_ADDR_W'(2);
			end
			step2,  step3,  step4,  step5,
			step6,  step7,  step8,  step9,
			step10, step11, step12, step13,
			step14, step15: begin
				// rN = r(N-1) + r(N-2)
				loadReg  = {1'b0, stepIdx[REG_ADDR_W-1:0]};
				readRegA = REG_ADDR_W'(stepIdx - 5'd1);
				readRegB = REG_ADDR_W'(stepIdx - 5'd2);
			end
			step16: begin
				// r15 | r15 on the bus, nothing written
				op       = opOr;
				readRegA = REG_ADDR_W'(REG_COUNT - 1);
				readRegB = REG_ADDR_W'(REG_COUNT - 1);
				done     = 1'b1;
			end
			default: begin
				// Same as step16 but not done, state recovers next cycle
				op       = opOr;
				loadReg  = '1;
				readRegA = REG_ADDR_W'(REG_COUNT - 1);
				readRegB = REG_ADDR_W'(REG_COUNT - 1);
			end
		endcase
	end

endmodule

/* hdl/fibTop.sv */
`timescale 1ns/1ps

module fibTop import fibPkg::*; #(
	parameter int DATA_W = 16
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [REG_ADDR_W-1:0] probeAddr,
	output logic [DATA_W-1:0]     probeData,
	output logic [DATA_W-1:0]     aluResult,
	output logic [REG_ADDR_W-1:0] writeAddr,
	output logic                  writeStrobe,
	output logic                  done,
	output logic                  zero
);

	// Microcode control fields
	logic [REG_ADDR_W:0]   loadReg;
	logic [REG_ADDR_W-1:0] readRegA;
	logic [REG_ADDR_W-1:0] readRegB;
	logic                  selectImm;
	logic [IMM_W-1:0]      imm;
	aluOp_t                op;

	// Register file read data
	logic [DATA_W-1:0] dataA;
	logic [DATA_W-1:0] dataB;

	assign writeAddr = loadReg[REG_ADDR_W-1:0];

	////////////////////////////////////////
	// Sequencer
	////////////////////////////////////////

	fibSequencer uSequencer (
		.clk       (clk),
		.rst       (rst),
		.loadReg   (loadReg),
		.readRegA  (readRegA),
		.readRegB  (readRegB),
		.selectImm (selectImm),
		.imm       (imm),
		.op        (op),
		.done      (done)
	);

	////////////////////////////////////////
	// Datapath
	////////////////////////////////////////

	// ALU result is written back in the same cycle
	regFile #(
		.DATA_W (DATA_W)
	) uRegFile (
		.clk         (clk),
		.rst         (rst),
		.loadReg     (loadReg),
		.writeData   (aluResult),
		.readRegA    (readRegA),
		.readRegB    (readRegB),
		.probeAddr   (probeAddr),
		.dataA       (dataA),
		.dataB       (dataB),
		.probeData   (probeData),
		.writeStrobe (writeStrobe)
	);

	alu #(
		.DATA_W (DATA_W)
	) uAlu (
		.op        (op),
		.selectImm (selectImm),
		.imm       (imm),
		.dataA     (dataA),
		.dataB     (dataB),
		.result    (aluResult),
		.zero      (zero)
	);

endmodule

/* test/fibTop_sva.sv */
`timescale 1ns/1ps

module fibTopChecks import fibPkg::*; #(
	parameter int DATA_W = 16
) (
	input  logic                  clk,
	input  logic                  rst,
	input  seqState_t             state,
	input  logic [DATA_W-1:0]     aluResult,
	input  logic [REG_ADDR_W-1:0] writeAddr,
	input  logic                  writeStrobe,
	input  logic                  done,
	input  logic                  zero
);

	// Failed assertions so far
	int failCount = 0;

	////////////////////////////////////////
	// Step order
	////////////////////////////////////////

	stepAfterReset: assert property (
		@(posedge clk) $past(rst) |-> state == step0
	) else begin
		failCount++;
		$error("Sequencer is not at step0 in the cycle after reset");
	end

	// One step per edge until the parking state
	stepAdvance: assert property (
		@(posedge clk) disable iff (rst)
		(!$past(rst) && $past(state) != step16) |-> 5'(state) == 5'($past(state)) + 5'd1
	) else begin
		failCount++;
		$error("Sequencer skipped or repeated a step");
	end

	stepPark: assert property (
		@(posedge clk) disable iff (rst)
		(!$past(rst) && $past(state) == step16) |-> state == step16
	) else begin
		failCount++;
		$error("Sequencer left step16 without a reset");
	end

	////////////////////////////////////////
	// Write port
	////////////////////////////////////////

	writeSlot: assert property (
		@(posedge clk) disable iff (rst)
		(state != step16) |-> writeStrobe && writeAddr == REG_ADDR_W'(state)
	) else begin
		failCount++;
		$error("Write address does not follow the step number");
	end

	// r0 and r1 start the series at one
	seedValues: assert property (
		@(posedge clk) disable iff (rst)
		(state == step0 || state == step1) |-> aluResult == DATA_W'(1)
	) else begin
		failCount++;
		$error("Seed write is not one");
	end

	// Each later write is the sum of the two writes before it
	fibSum: assert property (
		@(posedge clk) disable iff (rst)
		(state >= step2 && state <= step15) |->
			aluResult == DATA_W'($past(aluResult, 1) + $past(aluResult, 2))
	) else begin
		failCount++;
		$error("Write value is not the sum of the two previous writes");
	end

	////////////////////////////////////////
	// Done behavior
	////////////////////////////////////////

	// Done rises right after the r15 write and holds until reset
	doneLevel: assert property (
		@(posedge clk) disable iff (rst)
		done == (!$past(rst) && ($past(done) ||
			($past(writeStrobe) && $past(writeAddr) == REG_ADDR_W'(REG_COUNT - 1))))
	) else begin
		failCount++;
		$error("Done does not follow the last register write");
	end

	// r15 | r15 equals r15 so the bus keeps the last written value
	parkedOutputs: assert property (
		@(posedge clk) disable iff (rst)
		(state == step16) |-> !writeStrobe && !zero && aluResult == $past(aluResult)
	) else begin
		failCount++;
		$error("Outputs changed while parked in step16");
	end

endmodule

bind fibTop fibTopChecks #(
	.DATA_W (DATA_W)
) uChecks (
	.clk         (clk),
	.rst         (rst),
	.state       (uSequencer.state),
	.aluResult   (aluResult),
	.writeAddr   (writeAddr),
	.writeStrobe (writeStrobe),
	.done        (done),
	.zero        (zero)
);

/* test/fibTb.sv */
`timescale 1ns/1ps

module fibTb import fibPkg::*; ();

	localparam int DATA_W        = 16;
	localparam int CLK_PERIOD    = 40;
	localparam int HALF_PERIOD   = CLK_PERIOD / 2;
	localparam int SETTLE        = CLK_PERIOD / 4;
	localparam int RESET_CYCLES  = 4;
	localparam int DONE_CYCLES   = 10;
	localparam int PARTIAL_STEPS = 6;
	localparam int RANDOM_SEED   = 36;

	// Two full passes and a short one with a reset before each
	localparam int TEST_CYCLES =
		3 * RESET_CYCLES + 2 * (REG_COUNT + DONE_CYCLES) + PARTIAL_STEPS;
	localparam int WATCHDOG_CYCLES = TEST_CYCLES + 10;

	logic                  clk = 1'b0;
	logic                  rst;
	logic [REG_ADDR_W-1:0] probeAddr;
	logic [DATA_W-1:0]     probeData;
	logic [DATA_W-1:0]     aluResult;
	logic [REG_ADDR_W-1:0] writeAddr;
	logic                  writeStrobe;
	logic                  done;
	logic                  zero;

	// Expected register contents after the most recent clock edge
	logic [DATA_W-1:0] model [REG_COUNT];

	fibTop #(
		.DATA_W (DATA_W)
	) u_dut (
		.clk         (clk),
		.rst         (rst),
		.probeAddr   (probeAddr),
		.probeData   (probeData),
		.aluResult   (aluResult),
		.writeAddr   (writeAddr),
		.writeStrobe (writeStrobe),
		.done        (done),
		.zero        (zero)
	);

	initial begin
		forever begin
			#HALF_PERIOD clk = ~clk;
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("TEST FAIL");
		$fatal(1, "Timeout");
	end

	////////////////////////////////////////
	// Reporting
	////////////////////////////////////////

	task automatic reportMismatch(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		$display("** Error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, expected);
		$display("TEST FAIL");
		$fatal(1, "Value mismatch on %s", name);
	endtask

	task automatic reportFailure(input string reason);
		$display("Failure at %0t: %s", $time, reason);
		$display("TEST FAIL");
		$fatal(1, "%s", reason);
	endtask

	task automatic checkBound();
		assert (u_dut.uChecks.failCount == 0)
			else reportFailure("An assertion bound to fibTop has failed");
	endtask

	task automatic checkProbe();
		logic [DATA_W-1:0] expected;
		expected = model[probeAddr];
		assert (probeData == expected)
			else reportMismatch($sformatf("probeData (r%0d)", probeAddr),
				32'(probeData), 32'(expected));
	endtask

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	// Called at a falling edge or at time zero
	task automatic driveInputs(input logic rstLevel);
		rst       = rstLevel;
		probeAddr = REG_ADDR_W'($urandom());
	endtask

	task automatic applyReset();
		for (int i = 0; i < RESET_CYCLES; i++) begin
			driveInputs(1'b1);
			if (i == 0) begin
				// Registers clear on the coming edge
				model = '{default: '0};
			end else begin
				#SETTLE;
				checkBound();
				checkProbe();
				assert (!writeStrobe)
					else reportMismatch("writeStrobe", 32'(writeStrobe), 32'd0);
				assert (!done) else reportMismatch("done", 32'(done), 32'd0);
			end
			@(negedge clk);
		end
	endtask

	task automatic runStep(input logic [REG_ADDR_W-1:0] step);
		logic [DATA_W-1:0] expected;
		driveInputs(1'b0);
		#SETTLE;
		checkBound();
		checkProbe();
		// r0 and r1 seed the series
		if (step < REG_ADDR_W'(2)) begin
			expected = DATA_W'(1);
		end else begin
			expected = model[step - REG_ADDR_W'(1)] + model[step - REG_ADDR_W'(2)];
		end
		assert (writeStrobe) else reportMismatch("writeStrobe", 32'(writeStrobe), 32'd1);
		assert (writeAddr == step)
			else reportMismatch("writeAddr", 32'(writeAddr), 32'(step));
		assert (aluResult == expected)
			else reportMismatch("aluResult", 32'(aluResult), 32'(expected));
		assert (!done) else reportMismatch("done", 32'(done), 32'd0);
		assert (zero == (expected == '0))
			else reportMismatch("zero", 32'(zero), 32'(expected == '0));
		model[step] = expected;
		@(negedge clk);
	endtask

	task automatic runSequence();
		for (int k = 0; k < REG_COUNT; k++) begin
			runStep(REG_ADDR_W'(k));
		end
	endtask

	// Probes sweep the finished register file while parked in step16
	task automatic parkedCycle();
		logic [DATA_W-1:0] expected;
		driveInputs(1'b0);
		#SETTLE;
		checkBound();
		checkProbe();
		expected = model[REG_COUNT - 1] | model[REG_COUNT - 1];
		assert (done) else reportMismatch("done", 32'(done), 32'd1);
		assert (!writeStrobe)
			else reportMismatch("writeStrobe", 32'(writeStrobe), 32'd0);
		assert (aluResult == expected)
			else reportMismatch("aluResult", 32'(aluResult), 32'(expected));
		assert (!zero) else reportMismatch("zero", 32'(zero), 32'd0);
		@(negedge clk);
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		void'($urandom(RANDOM_SEED));
		rst       = 1'b1;
		probeAddr = '0;

		// First full pass
		applyReset();
		runSequence();
		repeat (DONE_CYCLES) parkedCycle();

		// Reset out of step16 drops done and the next pass is cut short
		applyReset();
		for (int k = 0; k < PARTIAL_STEPS; k++) begin
			runStep(REG_ADDR_W'(k));
		end

		// A reset in mid-run restarts the sequence from step 0
		applyReset();
		runSequence();
		repeat (DONE_CYCLES) parkedCycle();

		if (u_dut.uChecks.failCount == 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			$display("TEST FAIL");
			$fatal(1, "Bound assertions reported failures");
		end
	end

endmodule

/* list.f */
hdl/fibPkg.sv
hdl/alu.sv
hdl/regFile.sv
hdl/fibSequencer.sv
hdl/fibTop.sv
test/fibTop_sva.sv
test/fibTb.sv

/* Makefile */
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module fibTb -f list.f -Mdir obj_dir
	./obj_dir/VfibTb | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
